// ==== design/rob_enq_alloc.sv ====
`timescale 1ns/1ns

module rob_enq_alloc (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          instr0_enq_valid,
    input  logic [rob_pkg::pc_w-1:0]      instr0_pc,
    input  logic [rob_pkg::lreg_w-1:0]    instr0_lrd,
    input  logic [rob_pkg::preg_w-1:0]    instr0_prd,
    input  logic [rob_pkg::preg_w-1:0]    instr0_old_prd,
    input  logic                          instr0_need_to_wb,
    input  logic                          instr1_enq_valid,
    input  logic [rob_pkg::pc_w-1:0]      instr1_pc,
    input  logic [rob_pkg::lreg_w-1:0]    instr1_lrd,
    input  logic [rob_pkg::preg_w-1:0]    instr1_prd,
    input  logic [rob_pkg::preg_w-1:0]    instr1_old_prd,
    input  logic                          instr1_need_to_wb,
    input  logic                          rollback,
    input  rob_pkg::rob_ptr_t             flush_start,
    output rob_pkg::rob_ptr_t             enq_ptr,
    output logic [rob_pkg::rob_size-1:0]  enq_we,
    output logic [rob_pkg::pc_w-1:0]      enq_pc [rob_pkg::rob_size],
    output logic [rob_pkg::lreg_w-1:0]    enq_lrd [rob_pkg::rob_size],
    output logic [rob_pkg::preg_w-1:0]    enq_prd [rob_pkg::rob_size],
    output logic [rob_pkg::preg_w-1:0]    enq_old_prd [rob_pkg::rob_size],
    output logic [rob_pkg::rob_size-1:0]  enq_need_to_wb
);

    logic [rob_pkg::rob_idx_w-1:0] slot1_idx;
    logic [1:0]                    enq_cnt;
    rob_pkg::rob_ptr_t             enq_ptr_next;

    // second instruction lands one slot later, wrapping at the end
    assign slot1_idx = enq_ptr.f.idx + 1'b1;
    assign enq_cnt   = {1'b0, instr0_enq_valid} + {1'b0, instr1_enq_valid};

    always_comb begin
        for (int i = 0; i < rob_pkg::rob_size; i++) begin
            enq_we[i]         = 1'b0;
            enq_pc[i]         = instr0_pc;
            enq_lrd[i]        = instr0_lrd;
            enq_prd[i]        = instr0_prd;
            enq_old_prd[i]    = instr0_old_prd;
            enq_need_to_wb[i] = instr0_need_to_wb;
            if (instr0_enq_valid && (int'(enq_ptr.f.idx) == i)) begin
                enq_we[i] = 1'b1;
            end
            if (instr1_enq_valid && (int'(slot1_idx) == i)) begin
                enq_we[i]         = 1'b1;
                enq_pc[i]         = instr1_pc;
                enq_lrd[i]        = instr1_lrd;
                enq_prd[i]        = instr1_prd;
                enq_old_prd[i]    = instr1_old_prd;
                enq_need_to_wb[i] = instr1_need_to_wb;
            end
        end
    end

    // rollback restarts allocation right after the flushed entry
    always_comb begin
        if (rollback) begin
            enq_ptr_next.word = flush_start.word + 1'b1;
        end else begin
            enq_ptr_next.word = enq_ptr.word + {{(rob_pkg::rob_idx_w-1){1'b0}}, enq_cnt};
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
        end else begin
            enq_ptr <= enq_ptr_next;
        end
    end

endmodule

// ==== design/rob_entry_array.sv ====
`timescale 1ns/1ns

module rob_entry_array (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic [rob_pkg::rob_size-1:0]  enq_we,
    input  logic [rob_pkg::pc_w-1:0]      enq_pc [rob_pkg::rob_size],
    input  logic [rob_pkg::lreg_w-1:0]    enq_lrd [rob_pkg::rob_size],
    input  logic [rob_pkg::preg_w-1:0]    enq_prd [rob_pkg::rob_size],
    input  logic [rob_pkg::preg_w-1:0]    enq_old_prd [rob_pkg::rob_size],
    input  logic [rob_pkg::rob_size-1:0]  enq_need_to_wb,
    input  logic                          writeback0_valid,
    input  logic [rob_pkg::rob_idx_w-1:0] writeback0_robidx,
    input  logic                          writeback1_valid,
    input  logic [rob_pkg::rob_idx_w-1:0] writeback1_robidx,
    input  logic                          writeback1_mmio,
    input  logic                          writeback2_valid,
    input  logic [rob_pkg::rob_idx_w-1:0] writeback2_robidx,
    input  logic                          commit_valid,
    input  logic [rob_pkg::rob_idx_w-1:0] deq_idx,
    input  logic [rob_pkg::rob_idx_w-1:0] walk_idx,
    input  logic                          rollback,
    input  rob_pkg::rob_ptr_t             flush_start,
    input  rob_pkg::rob_ptr_t             enq_ptr,
    output logic [rob_pkg::rob_size-1:0]  entry_valid,
    output logic                          head_ready,
    output logic [rob_pkg::pc_w-1:0]      head_pc,
    output logic [rob_pkg::lreg_w-1:0]    head_lrd,
    output logic [rob_pkg::preg_w-1:0]    head_prd,
    output logic [rob_pkg::preg_w-1:0]    head_old_prd,
    output logic                          head_need_to_wb,
    output logic                          head_skip,
    output logic                          walk0_valid,
    output logic                          walk0_need_to_wb,
    output logic [rob_pkg::lreg_w-1:0]    walk0_lrd,
    output logic [rob_pkg::preg_w-1:0]    walk0_prd,
    output logic                          walk1_valid,
    output logic                          walk1_need_to_wb,
    output logic [rob_pkg::lreg_w-1:0]    walk1_lrd,
    output logic [rob_pkg::preg_w-1:0]    walk1_prd
);

    logic [rob_pkg::rob_size-1:0]  complete;
    logic [rob_pkg::rob_size-1:0]  skip;
    logic [rob_pkg::rob_size-1:0]  need_to_wb;
    logic [rob_pkg::pc_w-1:0]      ent_pc [rob_pkg::rob_size];
    logic [rob_pkg::lreg_w-1:0]    ent_lrd [rob_pkg::rob_size];
    logic [rob_pkg::preg_w-1:0]    ent_prd [rob_pkg::rob_size];
    logic [rob_pkg::preg_w-1:0]    ent_old_prd [rob_pkg::rob_size];

    logic [rob_pkg::rob_size-1:0]  wb_hit;
    logic [rob_pkg::rob_size-1:0]  skip_hit;
    logic [rob_pkg::rob_size-1:0]  clear;
    logic [rob_pkg::rob_idx_w-1:0] walk_idx1;

    assign walk_idx1 = walk_idx + 1'b1;

    always_comb begin
        for (int i = 0; i < rob_pkg::rob_size; i++) begin
            wb_hit[i] = (writeback0_valid && (int'(writeback0_robidx) == i)) ||
                        (writeback1_valid && (int'(writeback1_robidx) == i)) ||
                        (writeback2_valid && (int'(writeback2_robidx) == i));
            // only the load/store port reports mmio
            skip_hit[i] = writeback1_valid && writeback1_mmio &&
                          (int'(writeback1_robidx) == i);
            clear[i] = commit_valid && (int'(deq_idx) == i);
            // younger than the flush point, up to the allocation pointer
            if (rollback) begin
                if (enq_ptr.f.idx > flush_start.f.idx) begin
                    clear[i] = clear[i] || ((i > int'(flush_start.f.idx)) &&
                                            (i < int'(enq_ptr.f.idx)));
                end else begin
                    clear[i] = clear[i] || ((i > int'(flush_start.f.idx)) ||
                                            (i < int'(enq_ptr.f.idx)));
                end
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            entry_valid <= '0;
            complete    <= '0;
            skip        <= '0;
        end else begin
            for (int i = 0; i < rob_pkg::rob_size; i++) begin
                if (enq_we[i]) begin
                    entry_valid[i] <= 1'b1;
                    complete[i]    <= 1'b0;
                    skip[i]        <= 1'b0;
                end else if (clear[i]) begin
                    entry_valid[i] <= 1'b0;
                end else begin
                    if (wb_hit[i]) begin
                        complete[i] <= 1'b1;
                    end
                    if (skip_hit[i]) begin
                        skip[i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < rob_pkg::rob_size; i++) begin
            if (enq_we[i]) begin
                ent_pc[i]      <= enq_pc[i];
                ent_lrd[i]     <= enq_lrd[i];
                ent_prd[i]     <= enq_prd[i];
                ent_old_prd[i] <= enq_old_prd[i];
                need_to_wb[i]  <= enq_need_to_wb[i];
            end
        end
    end

    // head entry for commit
    assign head_ready      = entry_valid[deq_idx] && (complete[deq_idx] || !need_to_wb[deq_idx]);
    assign head_pc         = ent_pc[deq_idx];
    assign head_lrd        = ent_lrd[deq_idx];
    assign head_prd        = ent_prd[deq_idx];
    assign head_old_prd    = ent_old_prd[deq_idx];
    assign head_need_to_wb = need_to_wb[deq_idx];
    assign head_skip       = skip[deq_idx];

    // two walk slots
    assign walk0_valid      = entry_valid[walk_idx];
    assign walk0_need_to_wb = need_to_wb[walk_idx];
    assign walk0_lrd        = ent_lrd[walk_idx];
    assign walk0_prd        = ent_prd[walk_idx];
    assign walk1_valid      = entry_valid[walk_idx1];
    assign walk1_need_to_wb = need_to_wb[walk_idx1];
    assign walk1_lrd        = ent_lrd[walk_idx1];
    assign walk1_prd        = ent_prd[walk_idx1];

endmodule

// ==== design/rob_pkg.sv ====
package rob_pkg;

    // buffer geometry
    localparam int rob_size  = 16;
    localparam int rob_idx_w = 4;

    // payload field widths
    localparam int pc_w   = 64;
    localparam int lreg_w = 5;
    localparam int preg_w = 6;

    // recovery state encodings
    localparam int rob_state_w = 2;
    localparam logic [rob_state_w-1:0] st_idle      = 2'd0;
    localparam logic [rob_state_w-1:0] st_overwrite = 2'd1;
    localparam logic [rob_state_w-1:0] st_walking   = 2'd2;

    typedef struct packed {
        logic                 flag;
        logic [rob_idx_w-1:0] idx;
    } rob_ptr_fields_t;

    // counter view for wrapping arithmetic, field view for flag and index
    typedef union packed {
        logic [rob_idx_w:0] word;
        rob_ptr_fields_t    f;
    } rob_ptr_t;

endpackage

// ==== design/rob_retire.sv ====
`timescale 1ns/1ns

module rob_retire (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            flush_valid,
    input  logic                            flush_robidx_flag,
    input  logic [rob_pkg::rob_idx_w-1:0]   flush_robidx,
    input  logic                            head_ready,
    input  logic [rob_pkg::rob_size-1:0]    entry_valid,
    output logic                            commit_valid,
    output logic [rob_pkg::rob_idx_w-1:0]   deq_idx,
    output logic [rob_pkg::rob_idx_w-1:0]   walk_idx,
    output logic                            rollback,
    output rob_pkg::rob_ptr_t               flush_start,
    output logic [rob_pkg::rob_state_w-1:0] rob_state
);

    rob_pkg::rob_ptr_t             deq_ptr;
    logic [rob_pkg::rob_idx_w-1:0] walk_idx1;
    logic                          is_idle;
    logic                          is_walking;

    assign is_idle    = (rob_state == rob_pkg::st_idle);
    assign is_walking = (rob_state == rob_pkg::st_walking);
    assign rollback   = (rob_state == rob_pkg::st_overwrite);
    assign walk_idx1  = walk_idx + 1'b1;

    // one commit per cycle, held off by recovery and by an incoming flush
    assign commit_valid = head_ready && is_idle && !flush_valid;
    assign deq_idx      = deq_ptr.f.idx;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            deq_ptr <= '0;
        end else if (commit_valid) begin
            deq_ptr.word <= deq_ptr.word + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rob_state <= rob_pkg::st_idle;
        end else begin
            case (rob_state)
                rob_pkg::st_idle: begin
                    if (flush_valid) begin
                        rob_state <= rob_pkg::st_overwrite;
                    end
                end
                rob_pkg::st_overwrite: begin
                    rob_state <= rob_pkg::st_walking;
                end
                rob_pkg::st_walking: begin
                    // walk ends once the second slot runs off the live entries
                    if (!entry_valid[walk_idx1]) begin
                        rob_state <= rob_pkg::st_idle;
                    end
                end
                default: begin
                    rob_state <= rob_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            flush_start <= '0;
        end else if (is_idle && flush_valid) begin
            flush_start.f.flag <= flush_robidx_flag;
            flush_start.f.idx  <= flush_robidx;
        end
    end

    // walk starts from the oldest surviving entry
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            walk_idx <= '0;
        end else if (rollback) begin
            walk_idx <= deq_idx;
        end else if (is_walking) begin
            walk_idx <= walk_idx + 2'd2;
        end
    end

endmodule

// ==== design/rob_top.sv ====
`timescale 1ns/1ns

module rob_top (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            instr0_enq_valid,
    input  logic [rob_pkg::pc_w-1:0]        instr0_pc,
    input  logic [rob_pkg::lreg_w-1:0]      instr0_lrd,
    input  logic [rob_pkg::preg_w-1:0]      instr0_prd,
    input  logic [rob_pkg::preg_w-1:0]      instr0_old_prd,
    input  logic                            instr0_need_to_wb,
    input  logic                            instr1_enq_valid,
    input  logic [rob_pkg::pc_w-1:0]        instr1_pc,
    input  logic [rob_pkg::lreg_w-1:0]      instr1_lrd,
    input  logic [rob_pkg::preg_w-1:0]      instr1_prd,
    input  logic [rob_pkg::preg_w-1:0]      instr1_old_prd,
    input  logic                            instr1_need_to_wb,
    output logic                            enq_robidx_flag,
    output logic [rob_pkg::rob_idx_w-1:0]   enq_robidx,
    input  logic                            writeback0_valid,
    input  logic [rob_pkg::rob_idx_w-1:0]   writeback0_robidx,
    input  logic                            writeback1_valid,
    input  logic [rob_pkg::rob_idx_w-1:0]   writeback1_robidx,
    input  logic                            writeback1_mmio,
    input  logic                            writeback2_valid,
    input  logic [rob_pkg::rob_idx_w-1:0]   writeback2_robidx,
    output logic                            commits0_valid,
    output logic [rob_pkg::pc_w-1:0]        commits0_pc,
    output logic [rob_pkg::lreg_w-1:0]      commits0_lrd,
    output logic [rob_pkg::preg_w-1:0]      commits0_prd,
    output logic [rob_pkg::preg_w-1:0]      commits0_old_prd,
    output logic                            commits0_need_to_wb,
    output logic                            commits0_skip,
    input  logic                            flush_valid,
    input  logic                            flush_robidx_flag,
    input  logic [rob_pkg::rob_idx_w-1:0]   flush_robidx,
    output logic [rob_pkg::rob_state_w-1:0] rob_state,
    output logic                            rob_walk0_valid,
    output logic [rob_pkg::lreg_w-1:0]      rob_walk0_lrd,
    output logic [rob_pkg::preg_w-1:0]      rob_walk0_prd,
    output logic                            rob_walk1_valid,
    output logic [rob_pkg::lreg_w-1:0]      rob_walk1_lrd,
    output logic [rob_pkg::preg_w-1:0]      rob_walk1_prd
);

    rob_pkg::rob_ptr_t             enq_ptr;
    rob_pkg::rob_ptr_t             flush_start;
    logic [rob_pkg::rob_size-1:0]  enq_we;
    logic [rob_pkg::pc_w-1:0]      enq_pc [rob_pkg::rob_size];
    logic [rob_pkg::lreg_w-1:0]    enq_lrd [rob_pkg::rob_size];
    logic [rob_pkg::preg_w-1:0]    enq_prd [rob_pkg::rob_size];
    logic [rob_pkg::preg_w-1:0]    enq_old_prd [rob_pkg::rob_size];
    logic [rob_pkg::rob_size-1:0]  enq_need_to_wb;
    logic [rob_pkg::rob_size-1:0]  entry_valid;
    logic [rob_pkg::rob_idx_w-1:0] deq_idx;
    logic [rob_pkg::rob_idx_w-1:0] walk_idx;
    logic                          head_ready;
    logic                          rollback;
    logic                          walk0_valid;
    logic                          walk0_need_to_wb;
    logic                          walk1_valid;
    logic                          walk1_need_to_wb;
    logic                          walking;

    assign enq_robidx_flag = enq_ptr.f.flag;
    assign enq_robidx      = enq_ptr.f.idx;

    // rename table rebuild only sees live entries with a destination
    assign walking         = (rob_state == rob_pkg::st_walking);
    assign rob_walk0_valid = walk0_valid && walk0_need_to_wb && walking;
    assign rob_walk1_valid = walk1_valid && walk1_need_to_wb && walking;

    rob_enq_alloc u_enq_alloc (
        .clock(clock), .reset_n(reset_n),
        .instr0_enq_valid(instr0_enq_valid), .instr0_pc(instr0_pc),
        .instr0_lrd(instr0_lrd), .instr0_prd(instr0_prd),
        .instr0_old_prd(instr0_old_prd), .instr0_need_to_wb(instr0_need_to_wb),
        .instr1_enq_valid(instr1_enq_valid), .instr1_pc(instr1_pc),
        .instr1_lrd(instr1_lrd), .instr1_prd(instr1_prd),
        .instr1_old_prd(instr1_old_prd), .instr1_need_to_wb(instr1_need_to_wb),
        .rollback(rollback), .flush_start(flush_start),
        .enq_ptr(enq_ptr), .enq_we(enq_we), .enq_pc(enq_pc),
        .enq_lrd(enq_lrd), .enq_prd(enq_prd), .enq_old_prd(enq_old_prd),
        .enq_need_to_wb(enq_need_to_wb)
    );

    rob_entry_array u_entry_array (
        .clock(clock), .reset_n(reset_n),
        .enq_we(enq_we), .enq_pc(enq_pc), .enq_lrd(enq_lrd), .enq_prd(enq_prd),
        .enq_old_prd(enq_old_prd), .enq_need_to_wb(enq_need_to_wb),
        .writeback0_valid(writeback0_valid), .writeback0_robidx(writeback0_robidx),
        .writeback1_valid(writeback1_valid), .writeback1_robidx(writeback1_robidx),
        .writeback1_mmio(writeback1_mmio),
        .writeback2_valid(writeback2_valid), .writeback2_robidx(writeback2_robidx),
        .commit_valid(commits0_valid), .deq_idx(deq_idx), .walk_idx(walk_idx),
        .rollback(rollback), .flush_start(flush_start), .enq_ptr(enq_ptr),
        .entry_valid(entry_valid), .head_ready(head_ready),
        .head_pc(commits0_pc), .head_lrd(commits0_lrd), .head_prd(commits0_prd),
        .head_old_prd(commits0_old_prd), .head_need_to_wb(commits0_need_to_wb),
        .head_skip(commits0_skip),
        .walk0_valid(walk0_valid), .walk0_need_to_wb(walk0_need_to_wb),
        .walk0_lrd(rob_walk0_lrd), .walk0_prd(rob_walk0_prd),
        .walk1_valid(walk1_valid), .walk1_need_to_wb(walk1_need_to_wb),
        .walk1_lrd(rob_walk1_lrd), .walk1_prd(rob_walk1_prd)
    );

    rob_retire u_retire (
        .clock(clock), .reset_n(reset_n),
        .flush_valid(flush_valid), .flush_robidx_flag(flush_robidx_flag),
        .flush_robidx(flush_robidx), .head_ready(head_ready),
        .entry_valid(entry_valid), .commit_valid(commits0_valid),
        .deq_idx(deq_idx), .walk_idx(walk_idx), .rollback(rollback),
        .flush_start(flush_start), .rob_state(rob_state)
    );

endmodule

// ==== project.f ====
design/rob_pkg.sv
design/rob_enq_alloc.sv
design/rob_entry_array.sv
design/rob_retire.sv
design/rob_top.sv
test/rob_assert.sv
test/rob_tb.sv

// ==== test/rob_assert.sv ====
`timescale 1ns/1ns

module rob_assert (
    input logic                            clock,
    input logic                            reset_n,
    input logic [rob_pkg::rob_state_w-1:0] rob_state,
    input logic                            commits0_valid,
    input logic                            flush_valid,
    input logic                            rob_walk0_valid,
    input logic                            rob_walk1_valid
);

    int fail_count = 0;

    // commits only happen outside recovery
    assert property (@(posedge clock) disable iff (!reset_n)
        commits0_valid |-> rob_state == rob_pkg::st_idle)
        else begin
            $error("commit seen outside idle state");
            fail_count++;
        end

    assert property (@(posedge clock) disable iff (!reset_n)
        rob_state != 2'd3)
        else begin
            $error("illegal recovery state code");
            fail_count++;
        end

    assert property (@(posedge clock) disable iff (!reset_n)
        (rob_state == rob_pkg::st_idle && flush_valid) |=> rob_state == rob_pkg::st_overwrite)
        else begin
            $error("flush did not start overwrite");
            fail_count++;
        end

    // walk strobes belong to the walking state only
    assert property (@(posedge clock) disable iff (!reset_n)
        rob_state != rob_pkg::st_walking |-> !rob_walk0_valid && !rob_walk1_valid)
        else begin
            $error("walk valid outside walking state");
            fail_count++;
        end

endmodule

bind rob_top rob_assert u_rob_assert (
    .clock(clock), .reset_n(reset_n), .rob_state(rob_state),
    .commits0_valid(commits0_valid), .flush_valid(flush_valid),
    .rob_walk0_valid(rob_walk0_valid), .rob_walk1_valid(rob_walk1_valid)
);

// ==== test/rob_tb.sv ====
`timescale 1ns/1ns

module rob_tb;

    logic clock, reset_n;
    logic instr0_enq_valid, instr1_enq_valid, instr0_need_to_wb, instr1_need_to_wb;
    logic [63:0] instr0_pc, instr1_pc;
    logic [4:0] instr0_lrd, instr1_lrd;
    logic [5:0] instr0_prd, instr1_prd, instr0_old_prd, instr1_old_prd;
    logic enq_robidx_flag;
    logic [3:0] enq_robidx;
    logic writeback0_valid, writeback1_valid, writeback2_valid, writeback1_mmio;
    logic [3:0] writeback0_robidx, writeback1_robidx, writeback2_robidx;
    logic commits0_valid, commits0_need_to_wb, commits0_skip;
    logic [63:0] commits0_pc;
    logic [4:0] commits0_lrd;
    logic [5:0] commits0_prd, commits0_old_prd;
    logic flush_valid, flush_robidx_flag;
    logic [3:0] flush_robidx;
    logic [1:0] rob_state;
    logic rob_walk0_valid, rob_walk1_valid;
    logic [4:0] rob_walk0_lrd, rob_walk1_lrd;
    logic [5:0] rob_walk0_prd, rob_walk1_prd;

    // model entry {pc, lrd, prd, old_prd, need_to_wb, skip}
    logic [82:0] model[$];
    logic [4:0]  exp_ptr;
    int errors, tests_passed, tests_failed, cycles;
    integer seed = 32'h3e8e_c5e7;

    rob_top u_rob_top (.*);

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("run stopped, cycle limit reached");
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic enq_pair(input logic two, input logic need0, input logic need1);
        logic [82:0] e0, e1;
        e0 = 83'({$random(seed), $random(seed), $random(seed)});
        e1 = 83'({$random(seed), $random(seed), $random(seed)});
        e0[1:0] = {need0, 1'b0};
        e1[1:0] = {need1, 1'b0};
        @(posedge clock);
        instr0_enq_valid <= 1'b1;
        {instr0_pc, instr0_lrd, instr0_prd, instr0_old_prd, instr0_need_to_wb} <= e0[82:1];
        instr1_enq_valid <= two;
        {instr1_pc, instr1_lrd, instr1_prd, instr1_old_prd, instr1_need_to_wb} <= e1[82:1];
        model.push_back(e0);
        if (two) model.push_back(e1);
        exp_ptr = exp_ptr + (two ? 5'd2 : 5'd1);
    endtask

    task automatic writeback(input logic v0, input logic [3:0] i0, input logic v1,
                             input logic [3:0] i1, input logic mmio, input logic v2,
                             input logic [3:0] i2);
        @(posedge clock);
        writeback0_valid <= v0;
        writeback0_robidx <= i0;
        writeback1_valid <= v1;
        writeback1_robidx <= i1;
        writeback1_mmio <= mmio;
        writeback2_valid <= v2;
        writeback2_robidx <= i2;
    endtask

    task automatic release_inputs();
        @(posedge clock);
        instr0_enq_valid <= 1'b0;
        instr1_enq_valid <= 1'b0;
        writeback0_valid <= 1'b0;
        writeback1_valid <= 1'b0;
        writeback1_mmio <= 1'b0;
        writeback2_valid <= 1'b0;
        flush_valid <= 1'b0;
    endtask

    task automatic check_ptr();
        if ({enq_robidx_flag, enq_robidx} !== exp_ptr) begin
            $display("[FAIL] enq_robidx got %h expected %h",
                     {enq_robidx_flag, enq_robidx}, exp_ptr);
            errors++;
        end
    endtask

    // collect n commits in order, returning the cycles spent
    task automatic drain(input int n, output int spent);
        logic [82:0] got;
        int taken;
        taken = 0;
        spent = 0;
        while (taken < n && spent < 60) begin
            @(negedge clock);
            spent++;
            if (commits0_valid) begin
                got = {commits0_pc, commits0_lrd, commits0_prd, commits0_old_prd,
                       commits0_need_to_wb, commits0_skip};
                if (model.size() == 0) begin
                    $display("commit seen with no entry outstanding");
                    errors++;
                end else begin
                    if (got !== model[0]) begin
                        $display("[FAIL] commits0 fields got %h expected %h", got, model[0]);
                        errors++;
                    end
                    void'(model.pop_front());
                end
                taken++;
            end
        end
        if (taken < n) begin
            $display("only %0d of %0d commits arrived", taken, n);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    task automatic test_inorder_commit();
        int e0, spent;
        logic [4:0] b;
        e0 = errors;
        b = exp_ptr;
        repeat (3) enq_pair(1'b1, 1'b1, 1'b1);
        release_inputs();
        writeback(1'b1, 4'(b + 5), 1'b1, 4'(b + 4), 1'b0, 1'b1, 4'(b + 3));
        writeback(1'b1, 4'(b + 2), 1'b1, 4'(b + 1), 1'b0, 1'b1, 4'(b));
        @(negedge clock);
        if (commits0_valid) begin
            $display("commit before the head was written back");
            errors++;
        end
        check_ptr();
        release_inputs();
        drain(6, spent);
        if (spent != 6) begin
            $display("commits were not one per cycle, took %0d cycles", spent);
            errors++;
        end
        report("inorder_commit", e0);
    endtask

    task automatic test_no_writeback();
        int e0, spent;
        e0 = errors;
        enq_pair(1'b1, 1'b0, 1'b0);
        release_inputs();
        drain(2, spent);
        report("no_writeback", e0);
    endtask

    task automatic test_mmio_skip();
        int e0, spent;
        logic [4:0] b;
        logic [82:0] t;
        e0 = errors;
        b = exp_ptr;
        enq_pair(1'b1, 1'b1, 1'b1);
        release_inputs();
        t = model[model.size() - 2];
        t[0] = 1'b1;
        model[model.size() - 2] = t;
        // head written back last
        writeback(1'b0, 4'd0, 1'b1, 4'(b + 1), 1'b0, 1'b0, 4'd0);
        writeback(1'b0, 4'd0, 1'b1, 4'(b), 1'b1, 1'b0, 4'd0);
        release_inputs();
        drain(2, spent);
        report("mmio_skip", e0);
    endtask

    task automatic test_flush_walk();
        int e0, spent, k, j;
        logic [4:0] b, f;
        logic exp_v;
        logic got_v;
        logic [10:0] got_rd;
        e0 = errors;
        b = exp_ptr;
        enq_pair(1'b1, 1'b1, 1'($random(seed)));
        repeat (3) enq_pair(1'b1, 1'($random(seed)), 1'($random(seed)));
        release_inputs();
        f = b + 5'd3;
        @(posedge clock);
        flush_valid <= 1'b1;
        {flush_robidx_flag, flush_robidx} <= f;
        release_inputs();
        @(negedge clock);
        if (rob_state !== 2'd1) begin
            $display("[FAIL] rob_state got %h expected 1", rob_state);
            errors++;
        end
        @(negedge clock);
        k = 0;
        while (rob_state === 2'd2 && k < 20) begin
            for (j = 2 * k; j < 2 * k + 2; j++) begin
                exp_v = (j < 4) ? model[j][1] : 1'b0;
                got_v = (j % 2 == 0) ? rob_walk0_valid : rob_walk1_valid;
                got_rd = (j % 2 == 0) ? {rob_walk0_lrd, rob_walk0_prd}
                                      : {rob_walk1_lrd, rob_walk1_prd};
                if (got_v !== exp_v) begin
                    $display("[FAIL] rob_walk%0d_valid got %h expected %h", j % 2,
                             got_v, exp_v);
                    errors++;
                end else if (exp_v && got_rd !== model[j][18:8]) begin
                    $display("[FAIL] rob_walk%0d lrd/prd got %h expected %h", j % 2,
                             got_rd, model[j][18:8]);
                    errors++;
                end
            end
            k++;
            @(negedge clock);
        end
        if (k < 2 || rob_state !== 2'd0) begin
            $display("walk ended wrongly after %0d cycles", k);
            errors++;
        end
        while (model.size() > 4) void'(model.pop_back());
        exp_ptr = f + 5'd1;
        check_ptr();
        writeback(1'b1, 4'(b + 1), 1'b1, 4'(b + 2), 1'b0, 1'b1, 4'(b + 3));
        writeback(1'b1, 4'(b), 1'b0, 4'd0, 1'b0, 1'b0, 4'd0);
        release_inputs();
        drain(4, spent);
        report("flush_walk", e0);
    endtask

    task automatic test_wrap();
        int e0, spent;
        e0 = errors;
        repeat (10) begin
            enq_pair(1'b1, 1'b0, 1'b0);
            release_inputs();
            drain(2, spent);
            check_ptr();
        end
        report("wrap", e0);
    endtask

    initial begin
        clock = 1'b0;
        reset_n = 1'b0;
        {instr0_enq_valid, instr1_enq_valid, instr0_need_to_wb, instr1_need_to_wb} = '0;
        {instr0_pc, instr1_pc, instr0_lrd, instr1_lrd} = '0;
        {instr0_prd, instr1_prd, instr0_old_prd, instr1_old_prd} = '0;
        {writeback0_valid, writeback1_valid, writeback2_valid, writeback1_mmio} = '0;
        {writeback0_robidx, writeback1_robidx, writeback2_robidx} = '0;
        {flush_valid, flush_robidx_flag, flush_robidx} = '0;
        exp_ptr = '0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles = 0;
        repeat (10) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        if (rob_state !== 2'd0 || commits0_valid !== 1'b0) begin
            $display("state after reset is not idle with no commit");
            errors++;
        end
        check_ptr();
        test_inorder_commit();
        test_no_writeback();
        test_mmio_skip();
        test_flush_walk();
        test_wrap();
        if (u_rob_top.u_rob_assert.fail_count != 0) begin
            $display("bound assertions failed %0d times", u_rob_top.u_rob_assert.fail_count);
            errors += u_rob_top.u_rob_assert.fail_count;
        end
        $display("tests passed %0d, failed %0d, checks failed %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
